//--- execute_stage.f
src/ex_pkg.sv
src/ex_operand_fwd.sv
src/ex_alu.sv
src/ex_branch_resolve.sv
src/ex_mem_reg.sv
src/execute_stage.sv
sim/ex_clk_gen.sv
sim/execute_stage_tb.sv

//--- Bender.yml
package:
  name: execute_stage

sources:
  - src/ex_pkg.sv
  - src/ex_operand_fwd.sv
  - src/ex_alu.sv
  - src/ex_branch_resolve.sv
  - src/ex_mem_reg.sv
  - src/execute_stage.sv
  - target: simulation
    files:
      - sim/ex_clk_gen.sv
      - sim/execute_stage_tb.sv

//--- sim/execute_stage_tb.sv
/*
   Testbench for the execute stage with a table of
   instructions and hand-computed results, applied
   back to back with one idle slot, plus a reset
   check, timeout and error count
*/
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb;

   localparam int n_rows = 24;
   // Reset, one cycle per row, and some margin
   localparam int max_cycles = 10 + n_rows + 20;

   logic        clk, arst_n, in_valid;
   logic [15:0] oprnd_1, oprnd_2, rd_data_2, sext_imm, pc_inc;
   logic        alu_cin, alu_inv_a, alu_inv_b, alu_sign;
   logic [2:0]  alu_op;
   logic [1:0]  set_sel, br_cnd_sel;
   logic        br_instr, jmp_instr, jmp_reg_instr;
   logic [15:0] ex_rs_val, ex_rt_val, mem_rs_val, mem_rt_val;
   logic        ex_fwd_rs, ex_fwd_rt, mem_fwd_rs, mem_fwd_rt, mem_fwd_st;
   logic        out_valid, out_take_new_pc, out_set, out_ofl, out_zero;
   logic [15:0] out_alu_res, out_new_pc, out_lbi, out_slbi, out_st_data;

   // Stimulus columns are valid, op, {inv_a, inv_b, cin, sign}, a, b, imm,
   // set_sel, br_cnd_sel, {br, jmp, jmp_reg}, {ex_rs, ex_rt, mem_rs, mem_rt, mem_st}
   logic [67:0] stim [n_rows];
   // Expected columns are {take_new_pc, set, ofl, zero}, alu_res, new_pc, lbi, slbi, st_data
   logic [83:0] expd [n_rows];

   // Instruction context for the rows that follow
   logic [1:0]  m_ssel, m_bsel;
   logic [2:0]  m_kind;
   logic [4:0]  m_fwd;
   logic [15:0] m_imm, m_npc, m_st;

   int n_filled = 0;
   int errors = 0;
   int cycles = 0;
   int cur_row;

   ex_clk_gen #(.half_period(10)) u_clk (.clk);

   execute_stage #(.data_w(16)) UUT (.*);

   task automatic set_mode(input logic [1:0] ssel, input logic [1:0] bsel,
                           input logic [2:0] kind, input logic [4:0] fwd,
                           input logic [15:0] imm, input logic [15:0] npc,
                           input logic [15:0] st);
      {m_ssel, m_bsel, m_kind, m_fwd} = {ssel, bsel, kind, fwd};
      {m_imm, m_npc, m_st} = {imm, npc, st};
   endtask

   task automatic add_row(input logic [2:0] op, input logic [3:0] ctl,
                          input logic [15:0] a, input logic [15:0] b,
                          input logic [15:0] res, input logic [3:0] flg,
                          input logic [15:0] slbi);
      stim[n_filled] = {1'b1, op, ctl, a, b, m_imm, m_ssel, m_bsel, m_kind, m_fwd};
      expd[n_filled] = {flg, res, m_npc, m_imm, slbi, m_st};
      n_filled++;
   endtask

   // Previous results must hold while junk sits on the inputs
   task automatic add_idle();
      stim[n_filled] = {1'b0, ex_pkg::alu_and, 4'b1111, {3{16'hffff}}, 12'hfff};
      expd[n_filled] = expd[n_filled-1];
      n_filled++;
   endtask

   task automatic fill_table();
      // Shifts and rotates use only b[3:0]
      set_mode(ex_pkg::set_ofl, ex_pkg::br_eq, 3'b000, 5'b00000, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_rll, 4'b0000, 16'h8001, 16'h0014, 16'h0018, 4'b0000, 16'h0110);
      add_row(ex_pkg::alu_sll, 4'b0000, 16'hf0f3, 16'h0024, 16'h0f30, 4'b0000, 16'hf310);
      add_row(ex_pkg::alu_ror, 4'b0000, 16'h0012, 16'h0014, 16'h2001, 4'b0000, 16'h1210);
      add_row(ex_pkg::alu_srl, 4'b0000, 16'hf00f, 16'h0003, 16'h1e01, 4'b0000, 16'h0f10);
      // EX path wins when both paths forward
      set_mode(ex_pkg::set_ofl, ex_pkg::br_eq, 3'b000, 5'b11110, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0000, 16'haaaa, 16'h5555, 16'h3333, 4'b0000, 16'h1110);
      // Only the MEM path forwards and store data comes from MEM/WB
      set_mode(ex_pkg::set_ofl, ex_pkg::br_eq, 3'b000, 5'b00111, 16'h0010, 16'h0110, 16'h4444);
      add_row(ex_pkg::alu_or, 4'b0000, 16'haaaa, 16'h5555, 16'h7777, 4'b0000, 16'h3310);
      set_mode(ex_pkg::set_ofl, ex_pkg::br_eq, 3'b000, 5'b00000, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_xor, 4'b0000, 16'h0f0f, 16'h00ff, 16'h0ff0, 4'b0000, 16'h0f10);
      add_row(ex_pkg::alu_and, 4'b0000, 16'h0f0f, 16'h00ff, 16'h000f, 4'b0000, 16'h0f10);
      // Unsigned 5 - 3 where carry out means no borrow
      add_row(ex_pkg::alu_add, 4'b0110, 16'h0005, 16'h0003, 16'h0002, 4'b0110, 16'h0510);
      add_row(ex_pkg::alu_add, 4'b0001, 16'h7fff, 16'h0001, 16'h8000, 4'b0110, 16'hff10);
      set_mode(ex_pkg::set_zero, ex_pkg::br_eq, 3'b000, 5'b00000, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0000, 16'hffff, 16'h0001, 16'h0000, 4'b0111, 16'hff10);
      // Signed compares by subtraction
      set_mode(ex_pkg::set_lt, ex_pkg::br_eq, 3'b000, 5'b00000, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0111, 16'h0003, 16'h0005, 16'hfffe, 4'b0100, 16'h0310);
      set_mode(ex_pkg::set_lte, ex_pkg::br_eq, 3'b000, 5'b00000, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0111, 16'h0007, 16'h0007, 16'h0000, 4'b0101, 16'h0710);
      add_idle();
      // Branches with rs passed through the adder
      set_mode(ex_pkg::set_ofl, ex_pkg::br_eq, 3'b100, 5'b00000, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h0000, 16'h0000, 16'h0000, 4'b1001, 16'h0010);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h0001, 16'h0000, 16'h0001, 4'b0000, 16'h0110);
      set_mode(ex_pkg::set_ofl, ex_pkg::br_neq, 3'b100, 5'b00000, 16'hfff0, 16'h00f0, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h0001, 16'h0000, 16'h0001, 4'b1000, 16'h01f0);
      set_mode(ex_pkg::set_ofl, ex_pkg::br_neq, 3'b100, 5'b00000, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h0000, 16'h0000, 16'h0000, 4'b0001, 16'h0010);
      set_mode(ex_pkg::set_ofl, ex_pkg::br_lt, 3'b100, 5'b00000, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h8000, 16'h0000, 16'h8000, 4'b1000, 16'h0010);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h0004, 16'h0000, 16'h0004, 4'b0000, 16'h0410);
      set_mode(ex_pkg::set_ofl, ex_pkg::br_gteq, 3'b100, 5'b00000, 16'h0010, 16'h0110, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h0004, 16'h0000, 16'h0004, 4'b1000, 16'h0410);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h8000, 16'h0000, 16'h8000, 4'b0000, 16'h0010);
      // Direct jump and then a jump through a register
      set_mode(ex_pkg::set_ofl, ex_pkg::br_eq, 3'b010, 5'b00000, 16'h0020, 16'h0120, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h0000, 16'h0000, 16'h0000, 4'b1001, 16'h0020);
      set_mode(ex_pkg::set_ofl, ex_pkg::br_eq, 3'b001, 5'b00000, 16'h0006, 16'h0206, 16'h5a5a);
      add_row(ex_pkg::alu_add, 4'b0000, 16'h0200, 16'h0006, 16'h0206, 4'b1000, 16'h0006);
   endtask

   task automatic apply_inputs(input logic [67:0] v);
      {in_valid, alu_op, alu_inv_a, alu_inv_b, alu_cin, alu_sign, oprnd_1, oprnd_2,
       sext_imm, set_sel, br_cnd_sel, br_instr, jmp_instr, jmp_reg_instr,
       ex_fwd_rs, ex_fwd_rt, mem_fwd_rs, mem_fwd_rt, mem_fwd_st} <= v;
   endtask

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] want);
      assert (got === want) else begin
         errors++;
         $display("[FAIL] %0t row %0d: %s is %h, expected %h", $time, cur_row, name, got, want);
      end
   endtask

   task automatic check_outputs(input logic vld, input logic [83:0] e);
      logic [3:0]  flg;
      logic [15:0] res, npc, lbi, slbi, st;
      {flg, res, npc, lbi, slbi, st} = e;
      check_value("out_valid", out_valid, vld);
      check_value("out_take_new_pc", out_take_new_pc, flg[3]);
      check_value("out_set", out_set, flg[2]);
      check_value("out_ofl", out_ofl, flg[1]);
      check_value("out_zero", out_zero, flg[0]);
      check_value("out_alu_res", out_alu_res, res);
      check_value("out_new_pc", out_new_pc, npc);
      check_value("out_lbi", out_lbi, lbi);
      check_value("out_slbi", out_slbi, slbi);
      check_value("out_st_data", out_st_data, st);
   endtask

   initial begin
      arst_n     <= 1'b0;
      rd_data_2  <= 16'h5a5a;
      pc_inc     <= 16'h0100;
      ex_rs_val  <= 16'h1111;
      ex_rt_val  <= 16'h2222;
      mem_rs_val <= 16'h3333;
      mem_rt_val <= 16'h4444;
      apply_inputs('0);
      fill_table();
      assert (n_filled == n_rows) else begin
         errors++;
         $display("Table holds %0d rows instead of %0d", n_filled, n_rows);
      end
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      // Everything must still be zero before the first row
      @(negedge clk);
      cur_row = -1;
      check_outputs(1'b0, '0);
      for (int i = 0; i <= n_rows; i++) begin
         @(posedge clk);
         if (i < n_rows) begin
            apply_inputs(stim[i]);
         end else begin
            apply_inputs('0);
         end
         // Row i-1 was captured on this edge
         @(negedge clk);
         if (i > 0) begin
            cur_row = i - 1;
            check_outputs(stim[i-1][67], expd[i-1]);
         end
      end
      $display("Checks done, %0d error(s)", errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin
      while (cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/ex_clk_gen.sv
/*
   Free-running testbench clock,
   20 ns period
*/
`timescale 1ns/1ps
`default_nettype none

module ex_clk_gen #(
   parameter int half_period = 10
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

//--- src/execute_stage.sv
/*
   Execute stage top level:
   operand forwarding, ALU, branch and set
   resolution, and the EX/MEM register
*/
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
   parameter int data_w = ex_pkg::data_w_default
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              in_valid,
   input  logic [data_w-1:0] oprnd_1,
   input  logic [data_w-1:0] oprnd_2,
   input  logic [data_w-1:0] rd_data_2,
   input  logic [data_w-1:0] sext_imm,
   input  logic [data_w-1:0] pc_inc,
   input  logic              alu_cin,
   input  logic [2:0]        alu_op,
   input  logic              alu_inv_a,
   input  logic              alu_inv_b,
   input  logic              alu_sign,
   input  logic [1:0]        set_sel,
   input  logic [1:0]        br_cnd_sel,
   input  logic              br_instr,
   input  logic              jmp_instr,
   input  logic              jmp_reg_instr,
   input  logic [data_w-1:0] ex_rs_val,
   input  logic [data_w-1:0] ex_rt_val,
   input  logic [data_w-1:0] mem_rs_val,
   input  logic [data_w-1:0] mem_rt_val,
   input  logic              ex_fwd_rs,
   input  logic              ex_fwd_rt,
   input  logic              mem_fwd_rs,
   input  logic              mem_fwd_rt,
   input  logic              mem_fwd_st,
   output logic              out_valid,
   output logic              out_take_new_pc,
   output logic              out_set,
   output logic              out_ofl,
   output logic              out_zero,
   output logic [data_w-1:0] out_alu_res,
   output logic [data_w-1:0] out_new_pc,
   output logic [data_w-1:0] out_lbi,
   output logic [data_w-1:0] out_slbi,
   output logic [data_w-1:0] out_st_data
);

   logic [data_w-1:0] fwd_a, fwd_b, fwd_st;
   logic [data_w-1:0] alu_res, new_pc, lbi, slbi;
   logic              ofl, zero, lt, lte;
   logic              take_new_pc, set;

   ex_operand_fwd #(.data_w(data_w)) u_fwd (
      .oprnd_1, .oprnd_2, .rd_data_2, .ex_rs_val, .ex_rt_val, .mem_rs_val, .mem_rt_val,
      .ex_fwd_rs, .ex_fwd_rt, .mem_fwd_rs, .mem_fwd_rt, .mem_fwd_st,
      .fwd_a, .fwd_b, .fwd_st);

   ex_alu #(.data_w(data_w)) u_alu (
      .in_a(fwd_a), .in_b(fwd_b), .cin(alu_cin), .inv_a(alu_inv_a), .inv_b(alu_inv_b),
      .sign(alu_sign), .op(alu_op), .result(alu_res), .ofl, .zero, .lt, .lte);

   ex_branch_resolve #(.data_w(data_w)) u_br (
      .fwd_a, .alu_res, .sext_imm, .pc_inc, .zero, .ofl, .lt, .lte, .br_cnd_sel, .set_sel,
      .br_instr, .jmp_instr, .jmp_reg_instr, .take_new_pc, .set, .new_pc, .lbi, .slbi);

   // Everything leaving the stage goes through the EX/MEM register
   ex_mem_reg #(.data_w(data_w)) u_ex_mem (
      .clk, .arst_n, .in_valid, .take_new_pc, .set, .ofl, .zero, .alu_res, .new_pc,
      .lbi, .slbi, .st_data(fwd_st), .out_valid, .out_take_new_pc, .out_set, .out_ofl,
      .out_zero, .out_alu_res, .out_new_pc, .out_lbi, .out_slbi, .out_st_data);

endmodule

`default_nettype wire

//--- src/ex_mem_reg.sv
/*
   EX/MEM pipeline register:
   captures execute results on in_valid,
   holds them otherwise, delays the valid bit
*/
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg #(
   parameter int data_w = 16
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              in_valid,
   input  logic              take_new_pc,
   input  logic              set,
   input  logic              ofl,
   input  logic              zero,
   input  logic [data_w-1:0] alu_res,
   input  logic [data_w-1:0] new_pc,
   input  logic [data_w-1:0] lbi,
   input  logic [data_w-1:0] slbi,
   input  logic [data_w-1:0] st_data,
   output logic              out_valid,
   output logic              out_take_new_pc,
   output logic              out_set,
   output logic              out_ofl,
   output logic              out_zero,
   output logic [data_w-1:0] out_alu_res,
   output logic [data_w-1:0] out_new_pc,
   output logic [data_w-1:0] out_lbi,
   output logic [data_w-1:0] out_slbi,
   output logic [data_w-1:0] out_st_data
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid       <= 1'b0;
         out_take_new_pc <= 1'b0;
         out_set         <= 1'b0;
         out_ofl         <= 1'b0;
         out_zero        <= 1'b0;
         out_alu_res     <= '0;
         out_new_pc      <= '0;
         out_lbi         <= '0;
         out_slbi        <= '0;
         out_st_data     <= '0;
      end else begin
         out_valid <= in_valid;
         // Data holds while no instruction arrives
         if (in_valid) begin
            out_take_new_pc <= take_new_pc;
            out_set         <= set;
            out_ofl         <= ofl;
            out_zero        <= zero;
            out_alu_res     <= alu_res;
            out_new_pc      <= new_pc;
            out_lbi         <= lbi;
            out_slbi        <= slbi;
            out_st_data     <= st_data;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/ex_branch_resolve.sv
/*
   Branch and set resolution:
   branch condition, take decision, target PC,
   set flag select and the LBI / SLBI values
*/
`timescale 1ns/1ps
`default_nettype none

module ex_branch_resolve #(
   parameter int data_w = 16
) (
   input  logic [data_w-1:0] fwd_a,
   input  logic [data_w-1:0] alu_res,
   input  logic [data_w-1:0] sext_imm,
   input  logic [data_w-1:0] pc_inc,
   input  logic              zero,
   input  logic              ofl,
   input  logic              lt,
   input  logic              lte,
   input  logic [1:0]        br_cnd_sel,
   input  logic [1:0]        set_sel,
   input  logic              br_instr,
   input  logic              jmp_instr,
   input  logic              jmp_reg_instr,
   output logic              take_new_pc,
   output logic              set,
   output logic [data_w-1:0] new_pc,
   output logic [data_w-1:0] lbi,
   output logic [data_w-1:0] slbi
);

   localparam int half_w = data_w / 2;

   logic br_cond;

   // Branch conditions
   always_comb begin
      case (br_cnd_sel)
         ex_pkg::br_eq:  br_cond = zero;
         ex_pkg::br_neq: br_cond = ~zero;
         ex_pkg::br_lt:  br_cond = fwd_a[data_w-1];
         default:        br_cond = ~fwd_a[data_w-1];
      endcase
   end

   assign take_new_pc = jmp_instr | jmp_reg_instr | (br_instr & br_cond);

   // Register jumps get their target from the ALU (rs + imm)
   assign new_pc = jmp_reg_instr ? alu_res : (pc_inc + sext_imm);

   always_comb begin
      case (set_sel)
         ex_pkg::set_ofl:  set = ofl;
         ex_pkg::set_zero: set = zero;
         ex_pkg::set_lt:   set = lt;
         default:          set = lte;
      endcase
   end

   // Load immediates
   assign lbi  = sext_imm;
   assign slbi = {fwd_a[half_w-1:0], sext_imm[half_w-1:0]};

endmodule

`default_nettype wire

//--- src/ex_alu.sv
/*
   ALU of the execute stage:
   rotator, shifter, adder with carry-in and
   logic unit, operand inversion, and the
   overflow, zero and compare flags
*/
`timescale 1ns/1ps
`default_nettype none

module ex_alu #(
   parameter int data_w = 16
) (
   input  logic [data_w-1:0] in_a,
   input  logic [data_w-1:0] in_b,
   input  logic              cin,
   input  logic              inv_a,
   input  logic              inv_b,
   input  logic              sign,
   input  logic [2:0]        op,
   output logic [data_w-1:0] result,
   output logic              ofl,
   output logic              zero,
   output logic              lt,
   output logic              lte
);

   logic [data_w-1:0]   op_a;
   logic [data_w-1:0]   op_b;
   logic [3:0]          shamt;
   logic [2*data_w-1:0] rot_l;
   logic [2*data_w-1:0] rot_r;
   logic [data_w:0]     sum_full;
   logic [data_w-1:0]   sum;
   logic                cout;
   logic                sgn_ovf;

   // Operand inversion comes first, subtraction is inv_b with cin
   assign op_a = inv_a ? ~in_a : in_a;
   assign op_b = inv_b ? ~in_b : in_b;

   // Only the low four bits give the shift amount
   assign shamt = op_b[3:0];

   // Doubled word, so bits falling off one end reappear at the other
   assign rot_l = {op_a, op_a} << shamt;
   assign rot_r = {op_a, op_a} >> shamt;

   // Adder
   assign sum_full = {1'b0, op_a} + {1'b0, op_b} + {{data_w{1'b0}}, cin};
   assign sum      = sum_full[data_w-1:0];
   assign cout     = sum_full[data_w];

   // Same input signs but a different result sign
   assign sgn_ovf = (op_a[data_w-1] == op_b[data_w-1]) &&
                    (sum[data_w-1] != op_a[data_w-1]);

   always_comb begin
      case (op)
         ex_pkg::alu_rll: begin
            result = rot_l[2*data_w-1 -: data_w];
         end
         ex_pkg::alu_sll: begin
            result = op_a << shamt;
         end
         ex_pkg::alu_ror: begin
            result = rot_r[data_w-1:0];
         end
         ex_pkg::alu_srl: begin
            result = op_a >> shamt;
         end
         ex_pkg::alu_add: begin
            result = sum;
         end
         ex_pkg::alu_or: begin
            result = op_a | op_b;
         end
         ex_pkg::alu_xor: begin
            result = op_a ^ op_b;
         end
         default: begin
            result = op_a & op_b;
         end
      endcase
   end

   // Flags
   assign ofl  = sign ? sgn_ovf : cout;
   assign zero = (result == '0);

   // Signed: sign of the true sum; unsigned: a borrow happened
   assign lt  = sign ? (sum[data_w-1] ^ sgn_ovf) : ~cout;
   assign lte = lt | zero;

endmodule

`default_nettype wire

//--- src/ex_operand_fwd.sv
/*
   Operand forwarding for the execute stage:
   picks ALU operands and store data from the
   EX/MEM and MEM/WB bypass paths or from decode
*/
`timescale 1ns/1ps
`default_nettype none

module ex_operand_fwd #(
   parameter int data_w = 16
) (
   input  logic [data_w-1:0] oprnd_1,
   input  logic [data_w-1:0] oprnd_2,
   input  logic [data_w-1:0] rd_data_2,
   input  logic [data_w-1:0] ex_rs_val,
   input  logic [data_w-1:0] ex_rt_val,
   input  logic [data_w-1:0] mem_rs_val,
   input  logic [data_w-1:0] mem_rt_val,
   input  logic              ex_fwd_rs,
   input  logic              ex_fwd_rt,
   input  logic              mem_fwd_rs,
   input  logic              mem_fwd_rt,
   input  logic              mem_fwd_st,
   output logic [data_w-1:0] fwd_a,
   output logic [data_w-1:0] fwd_b,
   output logic [data_w-1:0] fwd_st
);

   // Newest value wins, so the EX/MEM path has priority
   assign fwd_a = ex_fwd_rs  ? ex_rs_val  :
                  mem_fwd_rs ? mem_rs_val :
                               oprnd_1;

   assign fwd_b = ex_fwd_rt  ? ex_rt_val  :
                  mem_fwd_rt ? mem_rt_val :
                               oprnd_2;

   // Store data only ever comes back from MEM/WB
   assign fwd_st = mem_fwd_st ? mem_rt_val : rd_data_2;

endmodule

`default_nettype wire

//--- src/ex_pkg.sv
/*
   Shared constants for the execute stage:
   default data width, ALU opcodes, set-select
   codes and branch-condition codes
*/
`default_nettype none

package ex_pkg;

   // Default datapath width
   localparam int data_w_default = 16;

   // ALU opcodes
   localparam logic [2:0] alu_rll = 3'd0;
   localparam logic [2:0] alu_sll = 3'd1;
   localparam logic [2:0] alu_ror = 3'd2;
   localparam logic [2:0] alu_srl = 3'd3;
   localparam logic [2:0] alu_add = 3'd4;
   localparam logic [2:0] alu_or  = 3'd5;
   localparam logic [2:0] alu_xor = 3'd6;
   localparam logic [2:0] alu_and = 3'd7;

   // Flag picked for the set instructions
   localparam logic [1:0] set_ofl  = 2'd0;
   localparam logic [1:0] set_zero = 2'd1;
   localparam logic [1:0] set_lt   = 2'd2;
   localparam logic [1:0] set_lte  = 2'd3;

   // Branch conditions
   // lt and gteq look only at the sign of the register operand
   localparam logic [1:0] br_eq   = 2'd0;
   localparam logic [1:0] br_neq  = 2'd1;
   localparam logic [1:0] br_lt   = 2'd2;
   localparam logic [1:0] br_gteq = 2'd3;

endpackage

`default_nettype wire
